/* project.f */
source/arbiter_pkg.sv
source/port_fifo.sv
source/age_compare.sv
source/packet_sequencer.sv
source/oldest_first_arbiter.sv
testbench/arbiter_sva.sv
testbench/tb_oldest_first_arbiter.sv

/* testbench/tb_oldest_first_arbiter.sv */
// Oldest-first arbiter testbench
module tb_oldest_first_arbiter;
  timeunit 1ns;
  timeprecision 1ps;

  // Longest packet that fits a port FIFO
  localparam int max_len = arbiter_pkg::fifo_depth - 1;

  // Cycle budget of each test, doubled for the run limit
  localparam int reset_cycles = 16;
  localparam int pass_cycles = 60;
  localparam int order_cycles = 60;
  localparam int lock_cycles = 40;
  localparam int pressure_cycles = 160;
  localparam int swrst_cycles = 40;
  localparam int timeout_cycles = 2 * (reset_cycles + pass_cycles + order_cycles +
    lock_cycles + pressure_cycles + swrst_cycles);

  logic                              axi_aclk;
  logic                              reset;
  logic                              sw_rst;
  arbiter_pkg::axis_beat_t           s_axis_beat [arbiter_pkg::num_ports];
  logic [arbiter_pkg::num_ports-1:0] s_axis_tvalid;
  logic [arbiter_pkg::num_ports-1:0] s_axis_tready;
  arbiter_pkg::axis_beat_t           m_axis_beat;
  logic                              m_axis_tvalid;
  logic                              m_axis_tready;

  // Staged packets, max_len slots per port
  arbiter_pkg::axis_beat_t pkt_mem [arbiter_pkg::num_ports * max_len];
  int                      pkt_len [arbiter_pkg::num_ports];

  // Expected master beats in leaving order, with their source port
  arbiter_pkg::axis_beat_t exp_q [$];
  arbiter_pkg::port_idx_t  exp_port_q [$];

  logic [31:0] lfsr;
  logic        packet_start;
  int          errors;
  int          checks;
  int          cycles;
  int          assert_fails;

  oldest_first_arbiter UUT (
    .axi_aclk      (axi_aclk),
    .reset         (reset),
    .sw_rst        (sw_rst),
    .s_axis_beat   (s_axis_beat),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .m_axis_beat   (m_axis_beat),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready)
  );

  always #2 axi_aclk = ~axi_aclk;

  always @(posedge axi_aclk) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("Timeout, the tests did not finish within %0d cycles", timeout_cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] lfsr_take(input int nbits);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int i = 0; i < nbits; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      value = {value[30:0], fb};
    end
    return value;
  endfunction

  task automatic expect_beat(input arbiter_pkg::axis_beat_t got,
                             input arbiter_pkg::axis_beat_t want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("Error at %0d ns: master beat %h, expected %h", $time, got, want);
    end
  endtask

  task automatic expect_port(input arbiter_pkg::port_idx_t got,
                             input arbiter_pkg::port_idx_t want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("Error at %0d ns: packet from port %0d, expected port %0d", $time, got, want);
    end
  endtask

  task automatic expect_flag(input logic got, input logic want, input string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("Error at %0d ns: %s is %b, expected %b", $time, what, got, want);
    end
  endtask

  task automatic make_packet(input arbiter_pkg::port_idx_t port, input int len,
                             input logic [31:0] ts);
    arbiter_pkg::axis_beat_t beat;
    logic [31:0] hi;
    logic [31:0] lo;
    logic [31:0] strb;
    logic [31:0] user_a;
    logic [31:0] user_b;
    logic [31:0] user_c;
    pkt_len[port] = len;
    for (int i = 0; i < len; i++) begin
      hi = lfsr_take(16);
      lo = lfsr_take(32);
      user_a = lfsr_take(32);
      user_b = lfsr_take(32);
      user_c = lfsr_take(32);
      // Port and beat number in the top bytes of tdata
      beat.tdata = {8'(port), 8'(i), hi[15:0], lo};
      beat.tlast = (i == len - 1);
      if (beat.tlast) begin
        strb = lfsr_take(8);
        beat.tstrb = strb[7:0] | 8'h01;
      end else begin
        beat.tstrb = '1;
      end
      beat.tuser = {user_a, user_b, user_c, user_a};
      beat.tuser[arbiter_pkg::ts_pos +: 32] = ts;
      pkt_mem[port * max_len + i] = beat;
    end
  endtask

  task automatic queue_expected(input arbiter_pkg::port_idx_t port);
    for (int i = 0; i < pkt_len[port]; i++) begin
      exp_q.push_back(pkt_mem[port * max_len + i]);
      exp_port_q.push_back(port);
    end
  endtask

  // Each beat moves on the rising edge after ready is seen high
  task automatic send_packet(input arbiter_pkg::port_idx_t port);
    @(negedge axi_aclk);
    for (int i = 0; i < pkt_len[port]; i++) begin
      s_axis_beat[port] = pkt_mem[port * max_len + i];
      s_axis_tvalid[port] = 1'b1;
      while (!s_axis_tready[port]) begin
        @(negedge axi_aclk);
      end
      @(negedge axi_aclk);
    end
    s_axis_tvalid[port] = 1'b0;
  endtask

  task automatic check_beat(input arbiter_pkg::axis_beat_t got);
    arbiter_pkg::port_idx_t src;
    src = arbiter_pkg::port_idx_t'(got.tdata[arbiter_pkg::data_width-1 -: 8]);
    if (exp_q.size() == 0) begin
      errors++;
      $display("A beat left the arbiter at %0d ns when none was expected", $time);
    end else begin
      if (packet_start) begin
        expect_port(src, exp_port_q[0]);
      end
      expect_beat(got, exp_q.pop_front());
      void'(exp_port_q.pop_front());
    end
    packet_start = got.tlast;
  endtask

  task automatic drain(input int nbeats, input logic random_ready);
    int          got;
    logic [31:0] draw;
    got = 0;
    while (got < nbeats) begin
      @(negedge axi_aclk);
      if (random_ready) begin
        draw = lfsr_take(1);
        m_axis_tready = draw[0];
      end else begin
        m_axis_tready = 1'b1;
      end
      if (m_axis_tvalid && m_axis_tready) begin
        check_beat(m_axis_beat);
        got++;
      end
    end
    // Last transfer completes before tready drops
    @(negedge axi_aclk);
    m_axis_tready = 1'b0;
  endtask

  task automatic pass_through();
    int          len;
    logic [31:0] draw;
    for (int p = 0; p < arbiter_pkg::num_ports; p++) begin
      draw = lfsr_take(2);
      len = 1 + int'(draw) % max_len;
      make_packet(arbiter_pkg::port_idx_t'(p), len, 32'h100 + p);
      queue_expected(arbiter_pkg::port_idx_t'(p));
      fork
        send_packet(arbiter_pkg::port_idx_t'(p));
        drain(len, 1'b0);
      join
    end
  endtask

  task automatic oldest_first();
    make_packet(2, 2, 32'h010);
    make_packet(0, 1, 32'h020);
    make_packet(3, 3, 32'h030);
    make_packet(1, 2, 32'h030);
    // Ascending timestamps, port 3 wins its tie with port 1
    queue_expected(2);
    queue_expected(0);
    queue_expected(3);
    queue_expected(1);
    // Oldest loaded first so the offered head holds while stalled
    send_packet(2);
    send_packet(1);
    send_packet(3);
    send_packet(0);
    drain(8, 1'b0);
  endtask

  task automatic no_interleave();
    make_packet(0, 3, 32'h100);
    make_packet(1, 1, 32'h005);
    queue_expected(0);
    queue_expected(1);
    send_packet(0);
    drain(1, 1'b0);
    // Older packet arrives while port 0 owns the stream
    send_packet(1);
    drain(3, 1'b0);
  endtask

  task automatic back_pressure();
    int          len;
    logic [31:0] draw;
    for (int i = 0; i < 4; i++) begin
      draw = lfsr_take(2);
      len = 1 + int'(draw) % max_len;
      make_packet(3, len, 32'h200 + i);
      queue_expected(3);
      fork
        send_packet(3);
        drain(len, 1'b1);
      join
    end
    // Port 2 fills to three entries
    make_packet(2, max_len, 32'h210);
    queue_expected(2);
    send_packet(2);
    expect_flag(s_axis_tready[2], 1'b0, "s_axis_tready[2] with three entries");
    drain(1, 1'b0);
    expect_flag(s_axis_tready[2], 1'b1, "s_axis_tready[2] after a pop");
    drain(max_len - 1, 1'b0);
  endtask

  task automatic soft_reset();
    make_packet(0, 2, 32'h300);
    make_packet(1, 3, 32'h301);
    send_packet(0);
    send_packet(1);
    @(negedge axi_aclk);
    sw_rst = 1'b1;
    @(negedge axi_aclk);
    sw_rst = 1'b0;
    m_axis_tready = 1'b1;
    repeat (3) begin
      @(negedge axi_aclk);
      expect_flag(m_axis_tvalid, 1'b0, "m_axis_tvalid after sw_rst");
    end
    for (int p = 0; p < arbiter_pkg::num_ports; p++) begin
      expect_flag(s_axis_tready[p], 1'b1, "s_axis_tready after sw_rst");
    end
    m_axis_tready = 1'b0;
    make_packet(2, 2, 32'h302);
    queue_expected(2);
    fork
      send_packet(2);
      drain(2, 1'b0);
    join
  endtask

  initial begin
    axi_aclk = 1'b0;
    reset = 1'b1;
    sw_rst = 1'b0;
    s_axis_tvalid = '0;
    m_axis_tready = 1'b0;
    for (int p = 0; p < arbiter_pkg::num_ports; p++) begin
      s_axis_beat[p] = '0;
    end
    lfsr = 32'h178d;
    packet_start = 1'b1;
    errors = 0;
    checks = 0;
    cycles = 0;
    repeat (reset_cycles) @(posedge axi_aclk);
    @(negedge axi_aclk);
    reset = 1'b0;

    pass_through();
    oldest_first();
    no_interleave();
    back_pressure();
    soft_reset();

    repeat (2) @(negedge axi_aclk);
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected beats never left the arbiter", exp_q.size());
    end
    assert_fails = UUT.u_sequencer.u_sva.failures;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* testbench/arbiter_sva.sv */
// Sequencer stream assertions
module arbiter_sva (
  input logic                              axi_aclk,
  input logic                              reset,
  input logic                              sw_rst,
  input logic [arbiter_pkg::num_ports-1:0] pops,
  input arbiter_pkg::axis_beat_t           m_axis_beat,
  input logic                              m_axis_tvalid,
  input logic                              m_axis_tready
);
  timeunit 1ns;
  timeprecision 1ps;

  // Failed assertions, read by the testbench at the end
  int failures = 0;

  // Offered beat holds under back-pressure
  hold_while_stalled: assert property (
    @(posedge axi_aclk) disable iff (reset || sw_rst)
    m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_beat)
  ) else begin
    failures++;
    $error("Master beat or valid changed while tready was low");
  end

  // Never more than one FIFO popped
  single_pop: assert property (
    @(posedge axi_aclk) disable iff (reset || sw_rst)
    $onehot0(pops)
  ) else begin
    failures++;
    $error("More than one FIFO popped in one cycle");
  end

  // A pop only goes with a master transfer
  pop_on_transfer: assert property (
    @(posedge axi_aclk) disable iff (reset || sw_rst)
    |pops |-> m_axis_tvalid && m_axis_tready
  ) else begin
    failures++;
    $error("FIFO popped without a master transfer");
  end

endmodule

bind packet_sequencer arbiter_sva u_sva (
  .axi_aclk      (axi_aclk),
  .reset         (reset),
  .sw_rst        (sw_rst),
  .pops          (pops),
  .m_axis_beat   (m_axis_beat),
  .m_axis_tvalid (m_axis_tvalid),
  .m_axis_tready (m_axis_tready)
);

/* source/oldest_first_arbiter.sv */
// Oldest-first stream arbiter
module oldest_first_arbiter (
  input  logic                              axi_aclk,
  input  logic                              reset,
  input  logic                              sw_rst,
  input  arbiter_pkg::axis_beat_t           s_axis_beat [arbiter_pkg::num_ports],
  input  logic [arbiter_pkg::num_ports-1:0] s_axis_tvalid,
  output logic [arbiter_pkg::num_ports-1:0] s_axis_tready,
  output arbiter_pkg::axis_beat_t           m_axis_beat,
  output logic                              m_axis_tvalid,
  input  logic                              m_axis_tready
);

  // FIFO heads and status toward the arbitration logic
  arbiter_pkg::axis_beat_t           heads [arbiter_pkg::num_ports];
  logic [arbiter_pkg::num_ports-1:0] empties;
  logic [arbiter_pkg::num_ports-1:0] pops;

  // Comparator result
  arbiter_pkg::port_idx_t oldest;

  // One receive FIFO per port
  for (genvar i = 0; i < arbiter_pkg::num_ports; i++) begin : g_port
    port_fifo u_fifo (
      .axi_aclk (axi_aclk),
      .reset    (reset),
      .sw_rst   (sw_rst),
      .in_beat  (s_axis_beat[i]),
      .in_valid (s_axis_tvalid[i]),
      .in_ready (s_axis_tready[i]),
      .pop      (pops[i]),
      .head     (heads[i]),
      .empty    (empties[i])
    );
  end

  age_compare u_age_compare (
    .heads   (heads),
    .empties (empties),
    .oldest  (oldest)
  );

  packet_sequencer u_sequencer (
    .axi_aclk      (axi_aclk),
    .reset         (reset),
    .sw_rst        (sw_rst),
    .oldest        (oldest),
    .heads         (heads),
    .empties       (empties),
    .pops          (pops),
    .m_axis_beat   (m_axis_beat),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready)
  );

endmodule

/* source/packet_sequencer.sv */
// Packet sequencer
module packet_sequencer (
  input  logic                              axi_aclk,
  input  logic                              reset,
  input  logic                              sw_rst,
  input  arbiter_pkg::port_idx_t            oldest,
  input  arbiter_pkg::axis_beat_t           heads [arbiter_pkg::num_ports],
  input  logic [arbiter_pkg::num_ports-1:0] empties,
  output logic [arbiter_pkg::num_ports-1:0] pops,
  output arbiter_pkg::axis_beat_t           m_axis_beat,
  output logic                              m_axis_tvalid,
  input  logic                              m_axis_tready
);

  // Low while awaiting a packet, high inside one
  logic in_packet;

  // Port that owns the packet in flight
  arbiter_pkg::port_idx_t locked_port;

  // Port currently offered on the master side
  arbiter_pkg::port_idx_t sel;

  logic xfer;
  logic first_beat;
  logic last_beat;

  // Between packets follow the comparator, inside one stay on the owner
  always_comb begin
    if (in_packet) begin
      sel = locked_port;
    end else begin
      sel = oldest;
    end
  end

  // Master stream straight from the chosen head
  assign m_axis_beat = heads[sel];
  assign m_axis_tvalid = !empties[sel];

  // Beat accepted downstream this cycle
  assign xfer = m_axis_tvalid && m_axis_tready;

  // Start and end of a multi-beat packet
  assign first_beat = xfer && !in_packet && !m_axis_beat.tlast;
  assign last_beat = xfer && in_packet && m_axis_beat.tlast;

  // One-hot pop on the port that just transferred
  always_comb begin
    pops = '0;
    if (xfer) begin
      pops[sel] = 1'b1;
    end
  end

  // Single-beat packets leave the state alone
  always_ff @(posedge axi_aclk) begin
    if (reset || sw_rst) begin
      in_packet <= 1'b0;
    end else if (first_beat) begin
      in_packet <= 1'b1;
    end else if (last_beat) begin
      in_packet <= 1'b0;
    end
  end

  // Capture the owner on the first beat of a packet
  always_ff @(posedge axi_aclk) begin
    if (reset || sw_rst) begin
      locked_port <= '0;
    end else if (first_beat) begin
      locked_port <= sel;
    end
  end

endmodule

/* source/age_compare.sv */
// Oldest head comparator
module age_compare (
  input  arbiter_pkg::axis_beat_t heads [arbiter_pkg::num_ports],
  input  logic [arbiter_pkg::num_ports-1:0] empties,
  output arbiter_pkg::port_idx_t            oldest
);

  // Sort key per port, empty flag on top of the timestamp
  logic [arbiter_pkg::ts_width:0] keys [arbiter_pkg::num_ports];

  // Running minimum along the chain
  logic [arbiter_pkg::ts_width:0] chain_key [arbiter_pkg::num_ports];
  arbiter_pkg::port_idx_t         chain_idx [arbiter_pkg::num_ports];

  // Empty ports get an all-ones key above any real timestamp
  for (genvar i = 0; i < arbiter_pkg::num_ports; i++) begin : g_key
    assign keys[i] = {
      empties[i],
      heads[i].tuser[arbiter_pkg::ts_pos +: arbiter_pkg::ts_width] |
        {arbiter_pkg::ts_width{empties[i]}}
    };
  end

  // Chain starts at port 0
  assign chain_key[0] = keys[0];
  assign chain_idx[0] = '0;

  // Strict less-than keeps the earlier port, so ties move to the later one
  for (genvar i = 1; i < arbiter_pkg::num_ports; i++) begin : g_chain
    logic keep_prev;

    assign keep_prev = (chain_key[i-1] < keys[i]);

    always_comb begin
      if (keep_prev) begin
        chain_key[i] = chain_key[i-1];
        chain_idx[i] = chain_idx[i-1];
      end else begin
        chain_key[i] = keys[i];
        chain_idx[i] = arbiter_pkg::port_idx_t'(i);
      end
    end
  end

  // Winner sits at the end of the chain
  assign oldest = chain_idx[arbiter_pkg::num_ports-1];

endmodule

/* source/port_fifo.sv */
// Per-port fall-through FIFO
module port_fifo (
  input  logic                    axi_aclk,
  input  logic                    reset,
  input  logic                    sw_rst,
  input  arbiter_pkg::axis_beat_t in_beat,
  input  logic                    in_valid,
  output logic                    in_ready,
  input  logic                    pop,
  output arbiter_pkg::axis_beat_t head,
  output logic                    empty
);

  // Beat storage
  arbiter_pkg::axis_beat_t mem [arbiter_pkg::fifo_depth];

  logic [arbiter_pkg::fifo_addr_bits-1:0] wr_ptr;
  logic [arbiter_pkg::fifo_addr_bits-1:0] rd_ptr;
  logic [arbiter_pkg::fifo_addr_bits:0]   count;

  logic wr_en;
  logic rd_en;
  logic nearly_full;

  // Nearly full once one slot is left
  assign nearly_full = (count >= arbiter_pkg::fifo_depth - 1);
  assign empty = (count == '0);

  // Upstream handshake
  assign in_ready = !nearly_full;
  assign wr_en = in_valid && in_ready;

  // A pop on an empty FIFO is ignored
  assign rd_en = pop && !empty;

  // Head is visible with no read latency
  assign head = mem[rd_ptr];

  always_ff @(posedge axi_aclk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_beat;
    end
  end

  // Pointers wrap on their own at the depth
  always_ff @(posedge axi_aclk) begin
    if (reset || sw_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Occupancy, unchanged on a simultaneous push and pop
  always_ff @(posedge axi_aclk) begin
    if (reset || sw_rst) begin
      count <= '0;
    end else begin
      case ({wr_en, rd_en})
        2'b10: begin
          count <= count + 1'b1;
        end
        2'b01: begin
          count <= count - 1'b1;
        end
        default: begin
          count <= count;
        end
      endcase
    end
  end

endmodule

/* source/arbiter_pkg.sv */
// Oldest-first arbiter definitions
package arbiter_pkg;

  // Stream widths
  localparam int data_width = 64;
  localparam int strb_width = data_width / 8;
  localparam int tuser_width = 128;

  // Receive ports and the width of a port index
  localparam int num_ports = 4;
  localparam int port_bits = 2;

  // Arrival timestamp field inside tuser
  localparam int ts_pos = 32;
  localparam int ts_width = 32;

  // Per-port FIFO sizing
  localparam int fifo_addr_bits = 2;
  localparam int fifo_depth = 1 << fifo_addr_bits;

  // One stream beat as it is buffered and forwarded
  typedef struct packed {
    logic [data_width-1:0]  tdata;
    logic [strb_width-1:0]  tstrb;
    logic [tuser_width-1:0] tuser;
    logic                   tlast;
  } axis_beat_t;

  // Index of a receive port
  typedef logic [port_bits-1:0] port_idx_t;

endpackage
